// File: common/lab_pkg.sv
`default_nettype none

package lab_pkg;

	// clocks per tick, a board build sets this to the clock rate
	localparam int unsigned TICK_DIV = 16;

	// wide enough to hold 0 .. TICK_DIV-1
	localparam int unsigned TICK_W = $clog2(TICK_DIV);

	// up-counter top value, wraps to 0 after it
	localparam int unsigned INC_MAX = 99;

	// alu function select
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_NOT = 3'd2,
		OP_AND = 3'd3,
		OP_OR  = 3'd4,
		OP_XOR = 3'd5,
		// signed a < b, result is 1 or 0
		OP_SLT = 3'd6,
		OP_EQ  = 3'd7
	} alu_op_e;

endpackage

`default_nettype wire

// File: design/tick_timer.sv
`default_nettype none

module tick_timer (
	input  logic clk,
	input  logic reset,
	output logic tick
);

	localparam logic [lab_pkg::TICK_W-1:0] LAST = lab_pkg::TICK_W'(lab_pkg::TICK_DIV - 1);

	logic [lab_pkg::TICK_W-1:0] div_q;
	logic [lab_pkg::TICK_W-1:0] div_next;

	// modulo TICK_DIV
	assign div_next = (div_q == LAST) ? '0 : div_q + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_q <= '0;
			tick  <= 1'b0;
		end else begin
			div_q <= div_next;
			// high for the cycle in which the divider sits at its last value
			tick  <= (div_next == LAST);
		end
	end

	a_tick_single: assert property (
		@(posedge clk) disable iff (reset)
		tick |=> !tick
	) else $error("tick high on two consecutive cycles");

endmodule

`default_nettype wire

// File: design/lab_counters.sv
`default_nettype none

module lab_counters (
	input  logic       clk,
	input  logic       reset,
	input  logic       tick,
	input  logic       count_en,
	output logic [6:0] inc_count,
	output logic [2:0] dec_count
);

	localparam logic [6:0] INC_TOP = 7'(lab_pkg::INC_MAX);

	logic step;

	// both counters move together on an enabled tick
	assign step = tick && count_en;

	// decimal up-counter, 0 .. INC_MAX
	always_ff @(posedge clk) begin
		if (reset) begin
			inc_count <= '0;
		end else if (step) begin
			if (inc_count == INC_TOP) begin
				inc_count <= '0;
			end else begin
				inc_count <= inc_count + 7'd1;
			end
		end
	end

	// 3-bit down-counter, 0 wraps to 7 on its own
	always_ff @(posedge clk) begin
		if (reset) begin
			dec_count <= '0;
		end else if (step) begin
			dec_count <= dec_count - 3'd1;
		end
	end

	a_inc_range: assert property (
		@(posedge clk) disable iff (reset)
		inc_count <= INC_TOP
	) else $error("inc_count above INC_MAX: %0d", inc_count);

endmodule

`default_nettype wire

// File: seg/seg_decimal.sv
`default_nettype none

module seg_decimal (
	input  logic       clk,
	input  logic       reset,
	input  logic [6:0] inc_count,
	output logic [7:0] seg0,
	output logic [7:0] seg1,
	output logic [7:0] seg2,
	output logic [7:0] seg3,
	output logic [7:0] seg4,
	output logic [7:0] seg5,
	output logic [7:0] seg6,
	output logic [7:0] seg7
);

	localparam int unsigned TENS_MAX = lab_pkg::INC_MAX / 10;
	localparam logic [7:0] BLANK = 8'hFF;

	// divide by ten through compares, the count never passes INC_MAX
	function automatic logic [3:0] tens_of(input logic [6:0] value);
		logic [3:0] tens;
		tens = '0;
		for (int unsigned i = 1; i <= TENS_MAX; i++) begin
			if (value >= 7'(i * 10)) begin
				tens = 4'(i);
			end
		end
		return tens;
	endfunction

	// active low, bit 0 is a, bit 6 is g, dp (bit 7) off
	function automatic logic [7:0] seg_pattern(input logic [3:0] digit);
		logic [7:0] pattern;
		case (digit)
			4'd0: pattern = 8'hC0;
			4'd1: pattern = 8'hF9;
			4'd2: pattern = 8'hA4;
			4'd3: pattern = 8'hB0;
			4'd4: pattern = 8'h99;
			4'd5: pattern = 8'h92;
			4'd6: pattern = 8'h82;
			4'd7: pattern = 8'hF8;
			4'd8: pattern = 8'h80;
			4'd9: pattern = 8'h90;
			default: pattern = BLANK;
		endcase
		return pattern;
	endfunction

	logic [3:0] tens;
	logic [3:0] ones;

	assign tens = tens_of(inc_count);
	assign ones = 4'(inc_count - 7'(tens * 10));

	always_ff @(posedge clk) begin
		if (reset) begin
			seg0 <= seg_pattern(4'd0);
			seg1 <= seg_pattern(4'd0);
		end else begin
			seg0 <= seg_pattern(ones);
			seg1 <= seg_pattern(tens);
		end
	end

	// upper six digits unused
	assign seg2 = BLANK;
	assign seg3 = BLANK;
	assign seg4 = BLANK;
	assign seg5 = BLANK;
	assign seg6 = BLANK;
	assign seg7 = BLANK;

endmodule

`default_nettype wire

// File: alu/alu_4bit.sv
`default_nettype none

module alu_4bit (
	input  lab_pkg::alu_op_e alu_op,
	input  logic [3:0]       alu_a,
	input  logic [3:0]       alu_b,
	output logic [3:0]       alu_res,
	output logic             alu_zero,
	output logic             alu_carry,
	output logic             alu_overflow
);

	logic [3:0] b_in;
	logic       carry_in;
	logic [4:0] sum;
	logic       add_ovf;
	logic       lt_signed;

	// subtract is a + ~b + 1
	always_comb begin
		b_in     = alu_b;
		carry_in = 1'b0;
		if (alu_op == lab_pkg::OP_SUB) begin
			b_in     = ~alu_b;
			carry_in = 1'b1;
		end
	end

	assign sum = {1'b0, alu_a} + {1'b0, b_in} + {4'd0, carry_in};

	// operands agree in sign, result does not
	assign add_ovf = (alu_a[3] == b_in[3]) && (sum[3] != alu_a[3]);

	assign lt_signed = $signed(alu_a) < $signed(alu_b);

	always_comb begin
		alu_res      = '0;
		alu_carry    = 1'b0;
		alu_overflow = 1'b0;
		case (alu_op)
			lab_pkg::OP_ADD,
			lab_pkg::OP_SUB: begin
				alu_res      = sum[3:0];
				alu_carry    = sum[4];
				alu_overflow = add_ovf;
			end
			lab_pkg::OP_NOT: begin
				alu_res = ~alu_a;
			end
			lab_pkg::OP_AND: begin
				alu_res = alu_a & alu_b;
			end
			lab_pkg::OP_OR: begin
				alu_res = alu_a | alu_b;
			end
			lab_pkg::OP_XOR: begin
				alu_res = alu_a ^ alu_b;
			end
			lab_pkg::OP_SLT: begin
				alu_res = {3'b000, lt_signed};
			end
			lab_pkg::OP_EQ: begin
				alu_res = {3'b000, alu_a == alu_b};
			end
			default: begin
				alu_res = '0;
			end
		endcase
	end

	assign alu_zero = (alu_res == 4'd0);

endmodule

`default_nettype wire

// File: design/barrel_shifter.sv
`default_nettype none

module barrel_shifter (
	input  logic [31:0] data,
	input  logic [4:0]  shamt,
	input  logic        shift_left,
	input  logic        arith,
	output logic [31:0] shift_q
);

	// stage k holds the word after the lower k shamt bits are applied
	logic [5:0][31:0] stage;
	logic             fill;

	// sign fill only for arithmetic right shifts
	assign fill = arith & data[31] & ~shift_left;

	assign stage[0] = data;

	for (genvar i = 0; i < 5; i++) begin : g_stage
		localparam int AMT = 1 << i;

		assign stage[i+1] = !shamt[i]  ? stage[i] :
		                    shift_left ? {stage[i][31-AMT:0], {AMT{1'b0}}} :
		                                 {{AMT{fill}}, stage[i][31:AMT]};
	end

	assign shift_q = stage[5];

endmodule

`default_nettype wire

// File: design/lab_top.sv
`default_nettype none

module lab_top (
	input  logic             clk,
	input  logic             reset,
	input  logic             count_en,
	input  lab_pkg::alu_op_e alu_op,
	input  logic [3:0]       alu_a,
	input  logic [3:0]       alu_b,
	input  logic [31:0]      sft_data,
	input  logic [4:0]       sft_shamt,
	input  logic             sft_left,
	input  logic             sft_arith,
	output logic [6:0]       inc_count,
	output logic [2:0]       dec_count,
	output logic [7:0]       seg0,
	output logic [7:0]       seg1,
	output logic [7:0]       seg2,
	output logic [7:0]       seg3,
	output logic [7:0]       seg4,
	output logic [7:0]       seg5,
	output logic [7:0]       seg6,
	output logic [7:0]       seg7,
	output logic [3:0]       alu_res,
	output logic             alu_zero,
	output logic             alu_carry,
	output logic             alu_overflow,
	output logic [31:0]      sft_q
);

	logic tick;

	tick_timer u_timer (
		.clk  (clk),
		.reset(reset),
		.tick (tick)
	);

	lab_counters u_counters (
		.clk      (clk),
		.reset    (reset),
		.tick     (tick),
		.count_en (count_en),
		.inc_count(inc_count),
		.dec_count(dec_count)
	);

	// display trails the count by one register stage
	seg_decimal u_seg (
		.clk      (clk),
		.reset    (reset),
		.inc_count(inc_count),
		.seg0     (seg0),
		.seg1     (seg1),
		.seg2     (seg2),
		.seg3     (seg3),
		.seg4     (seg4),
		.seg5     (seg5),
		.seg6     (seg6),
		.seg7     (seg7)
	);

	alu_4bit u_alu (
		.alu_op      (alu_op),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.alu_res     (alu_res),
		.alu_zero    (alu_zero),
		.alu_carry   (alu_carry),
		.alu_overflow(alu_overflow)
	);

	barrel_shifter u_shifter (
		.data      (sft_data),
		.shamt     (sft_shamt),
		.shift_left(sft_left),
		.arith     (sft_arith),
		.shift_q   (sft_q)
	);

	// opcode into the alu must be driven once out of reset
	a_alu_op_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(alu_op)
	) else $error("alu_op unknown");

endmodule

`default_nettype wire

// File: verif/tb_lab_top.sv
`default_nettype none

module tb_lab_top;

	timeunit 1ns;
	timeprecision 100ps;

	// 105 ticks of counting, enable test, 8 x 200 alu and 200 shift vectors, plus margin
	localparam int unsigned TIMEOUT_CYCLES = 4000;
	localparam int unsigned COUNT_TICKS = 105;
	localparam int unsigned VECTORS = 200;

	logic             clk;
	logic             reset;
	logic             count_en;
	lab_pkg::alu_op_e alu_op;
	logic [3:0]       alu_a;
	logic [3:0]       alu_b;
	logic [31:0]      sft_data;
	logic [4:0]       sft_shamt;
	logic             sft_left;
	logic             sft_arith;
	logic [6:0]       inc_count;
	logic [2:0]       dec_count;
	logic [7:0]       seg0;
	logic [7:0]       seg1;
	logic [7:0]       seg2;
	logic [7:0]       seg3;
	logic [7:0]       seg4;
	logic [7:0]       seg5;
	logic [7:0]       seg6;
	logic [7:0]       seg7;
	logic [3:0]       alu_res;
	logic             alu_zero;
	logic             alu_carry;
	logic             alu_overflow;
	logic [31:0]      sft_q;

	logic [15:0]      lfsr;
	logic [6:0]       exp_inc;
	logic [2:0]       exp_dec;
	int unsigned      edge_cnt;
	int unsigned      cycle_cnt;

	lab_top UUT (
		.clk         (clk),
		.reset       (reset),
		.count_en    (count_en),
		.alu_op      (alu_op),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.sft_data    (sft_data),
		.sft_shamt   (sft_shamt),
		.sft_left    (sft_left),
		.sft_arith   (sft_arith),
		.inc_count   (inc_count),
		.dec_count   (dec_count),
		.seg0        (seg0),
		.seg1        (seg1),
		.seg2        (seg2),
		.seg3        (seg3),
		.seg4        (seg4),
		.seg5        (seg5),
		.seg6        (seg6),
		.seg7        (seg7),
		.alu_res     (alu_res),
		.alu_zero    (alu_zero),
		.alu_carry   (alu_carry),
		.alu_overflow(alu_overflow),
		.sft_q       (sft_q)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$fatal(1, "stopped on timeout");
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int unsigned n, output logic [31:0] v);
		v = '0;
		for (int unsigned i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s expected 0x%0h got 0x%0h", name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// active-low patterns built from lit segments a (bit 0) to g (bit 6)
	function automatic logic [7:0] ref_seg(input int unsigned digit);
		logic [6:0] lit;
		case (digit)
			0: lit = 7'h3F;
			1: lit = 7'h06;
			2: lit = 7'h5B;
			3: lit = 7'h4F;
			4: lit = 7'h66;
			5: lit = 7'h6D;
			6: lit = 7'h7D;
			7: lit = 7'h07;
			8: lit = 7'h7F;
			9: lit = 7'h6F;
			default: lit = 7'h00;
		endcase
		return ~{1'b0, lit};
	endfunction

	// packed as {overflow, carry, zero, result}
	function automatic logic [6:0] ref_alu(input lab_pkg::alu_op_e op, input logic [3:0] a,
			input logic [3:0] b);
		int         ua;
		int         ub;
		int         sa;
		int         sb;
		int         total;
		int         sres;
		logic [3:0] res;
		logic       carry;
		logic       ovf;
		ua = a;
		ub = b;
		sa = a[3] ? ua - 16 : ua;
		sb = b[3] ? ub - 16 : ub;
		res = '0;
		carry = 1'b0;
		ovf = 1'b0;
		case (op)
			lab_pkg::OP_ADD: begin
				total = ua + ub;
				res = 4'(total);
				carry = (total > 15);
				sres = sa + sb;
				ovf = (sres > 7) || (sres < -8);
			end
			lab_pkg::OP_SUB: begin
				total = ua + (15 - ub) + 1;
				res = 4'(total);
				carry = (total > 15);
				sres = sa - sb;
				ovf = (sres > 7) || (sres < -8);
			end
			lab_pkg::OP_NOT: res = 4'(15 - ua);
			lab_pkg::OP_AND: res = a & b;
			lab_pkg::OP_OR:  res = a | b;
			lab_pkg::OP_XOR: res = a ^ b;
			lab_pkg::OP_SLT: res = (sa < sb) ? 4'd1 : 4'd0;
			lab_pkg::OP_EQ:  res = (ua == ub) ? 4'd1 : 4'd0;
			default: res = '0;
		endcase
		return {ovf, carry, res == 4'd0, res};
	endfunction

	// fill bit depends on direction and mode
	function automatic logic [31:0] ref_shift(input logic [31:0] d, input int unsigned amt,
			input logic left, input logic arith);
		logic [31:0] q;
		int          src;
		for (int i = 0; i < 32; i++) begin
			if (left) begin
				src = i - int'(amt);
				q[i] = (src >= 0) ? d[src] : 1'b0;
			end else begin
				src = i + int'(amt);
				q[i] = (src <= 31) ? d[src] : (arith & d[31]);
			end
		end
		return q;
	endfunction

	// one clock of the counter model and its checks after the edge
	task automatic count_cycle();
		logic [6:0] shown;
		@(posedge clk);
		edge_cnt++;
		shown = exp_inc;
		if ((edge_cnt % lab_pkg::TICK_DIV) == 0 && count_en) begin
			exp_inc = (exp_inc == 7'(lab_pkg::INC_MAX)) ? 7'd0 : exp_inc + 7'd1;
			exp_dec = exp_dec - 3'd1;
		end
		#2;
		check("inc_count", 32'(exp_inc), 32'(inc_count));
		check("dec_count", 32'(exp_dec), 32'(dec_count));
		check("seg0", 32'(ref_seg(shown % 10)), 32'(seg0));
		check("seg1", 32'(ref_seg(shown / 10)), 32'(seg1));
	endtask

	task automatic apply_alu(input lab_pkg::alu_op_e op, input logic [3:0] a,
			input logic [3:0] b);
		logic [6:0] exp;
		@(posedge clk);
		#2;
		alu_op = op;
		alu_a = a;
		alu_b = b;
		#5;
		exp = ref_alu(op, a, b);
		check("alu_res", 32'(exp[3:0]), 32'(alu_res));
		check("alu_zero", 32'(exp[4]), 32'(alu_zero));
		check("alu_carry", 32'(exp[5]), 32'(alu_carry));
		check("alu_overflow", 32'(exp[6]), 32'(alu_overflow));
	endtask

	task automatic apply_shift(input logic [31:0] d, input logic [4:0] amt,
			input logic left, input logic arith);
		@(posedge clk);
		#2;
		sft_data = d;
		sft_shamt = amt;
		sft_left = left;
		sft_arith = arith;
		#5;
		check("sft_q", ref_shift(d, amt, left, arith), sft_q);
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] r2;
		clk = 1'b0;
		reset = 1'b1;
		count_en = 1'b0;
		alu_op = lab_pkg::OP_ADD;
		alu_a = '0;
		alu_b = '0;
		sft_data = '0;
		sft_shamt = '0;
		sft_left = 1'b0;
		sft_arith = 1'b0;
		lfsr = 16'd43;
		exp_inc = '0;
		exp_dec = '0;
		edge_cnt = 0;
		cycle_cnt = 0;

		repeat (2) @(posedge clk);
		#2;
		check("inc_count", 32'd0, 32'(inc_count));
		check("dec_count", 32'd0, 32'(dec_count));
		check("seg0", 32'(ref_seg(0)), 32'(seg0));
		check("seg1", 32'(ref_seg(0)), 32'(seg1));
		check("seg2", 32'hFF, 32'(seg2));
		check("seg3", 32'hFF, 32'(seg3));
		check("seg4", 32'hFF, 32'(seg4));
		check("seg5", 32'hFF, 32'(seg5));
		check("seg6", 32'hFF, 32'(seg6));
		check("seg7", 32'hFF, 32'(seg7));
		reset = 1'b0;
		count_en = 1'b1;

		// through the 99 to 0 wrap plus two cycles for the display
		repeat (COUNT_TICKS * lab_pkg::TICK_DIV + 2) count_cycle();

		count_en = 1'b0;
		repeat (4 * lab_pkg::TICK_DIV) count_cycle();
		count_en = 1'b1;
		repeat (3 * lab_pkg::TICK_DIV + 2) count_cycle();

		for (int k = 0; k < 8; k++) begin
			for (int unsigned i = 0; i < VECTORS; i++) begin
				take_bits(4, r);
				take_bits(4, r2);
				apply_alu(lab_pkg::alu_op_e'(3'(k)), r[3:0], r2[3:0]);
			end
		end
		apply_alu(lab_pkg::OP_ADD, 4'd7, 4'd1);
		apply_alu(lab_pkg::OP_ADD, 4'd15, 4'd1);
		apply_alu(lab_pkg::OP_SUB, 4'd0, 4'd1);
		apply_alu(lab_pkg::OP_SLT, 4'd8, 4'd7);

		// low two bits of the index walk all direction and mode pairs
		for (int unsigned i = 0; i < VECTORS; i++) begin
			take_bits(32, r);
			take_bits(5, r2);
			apply_shift(r, r2[4:0], i[0], i[1]);
		end
		apply_shift(32'h1234_5678, 5'd0, 1'b1, 1'b0);
		apply_shift(32'h8000_0001, 5'd31, 1'b0, 1'b1);
		apply_shift(32'h8000_0001, 5'd31, 1'b1, 1'b0);
		apply_shift(32'h9000_00F0, 5'd8, 1'b0, 1'b1);

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
common/lab_pkg.sv
design/tick_timer.sv
design/lab_counters.sv
seg/seg_decimal.sv
alu/alu_4bit.sv
design/barrel_shifter.sv
design/lab_top.sv
verif/tb_lab_top.sv
